// ==== source/rv_pkg.sv ====
package rv_pkg;

	// ##########################################################################
	// widths
	// ##########################################################################

	typedef logic [31:0] word_t;     // memory word or expanded instruction.
	typedef logic [15:0] half_t;     // one instruction parcel.
	typedef logic [31:0] pc_t;       // byte address.
	typedef logic [4:0]  reg_addr_t;

	localparam pc_t RESET_PC = 32'h0000_0000;

	// ##########################################################################
	// base opcodes
	// ##########################################################################

	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// alu funct3.
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SR  = 3'b101;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// memory and branch funct3.
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_SW  = 3'b010;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	localparam logic [6:0] F7_ALT = 7'b0100000; // sub, srai.

	// ##########################################################################
	// registers
	// ##########################################################################

	localparam reg_addr_t REG_ZERO = 5'd0;
	localparam reg_addr_t REG_RA   = 5'd1; // link register.
	localparam reg_addr_t REG_SP   = 5'd2;

	// ##########################################################################
	// fetch
	// ##########################################################################

	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0, // no request outstanding.
		FETCH_WAIT = 2'd1, // response will be used.
		FETCH_DROP = 2'd2  // response is stale.
	} fetch_state_e;

	// one instruction as handed to the decoder.
	typedef struct packed {
		word_t instr;
		pc_t   pc;
		logic  is_32bit;
		logic  illegal;
	} fetch_out_t;

endpackage

// ==== source/instr_decompress.sv ====
`timescale 1ns/1ps

module instr_decompress (
	input  rv_pkg::half_t      head_lo,
	input  rv_pkg::half_t      head_hi,
	input  rv_pkg::pc_t        head_pc,
	output rv_pkg::fetch_out_t out
);

	// ##########################################################################
	// base format encoders
	// ##########################################################################

	function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
		input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
		input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input rv_pkg::reg_addr_t rs2,
		input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input rv_pkg::reg_addr_t rs2,
		input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
	endfunction

	function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input rv_pkg::reg_addr_t rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input rv_pkg::reg_addr_t rd,
		input logic [6:0] opc);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
	endfunction

	rv_pkg::half_t c;
	assign c = head_lo;

	// full register fields for cr, ci, css. short ones map to x8..x15.
	rv_pkg::reg_addr_t rd_l;
	rv_pkg::reg_addr_t rs2_l;
	rv_pkg::reg_addr_t rd_s;
	rv_pkg::reg_addr_t rs1_s;
	rv_pkg::reg_addr_t rs2_s;
	assign rd_l  = c[11:7];
	assign rs2_l = c[6:2];
	assign rd_s  = {2'b01, c[4:2]};
	assign rs1_s = {2'b01, c[9:7]};
	assign rs2_s = {2'b01, c[4:2]};

	logic [11:0] imm_ci;
	logic [20:0] imm_cj;
	logic [12:0] imm_cb;
	logic [11:0] imm_lw;
	logic [11:0] imm_4spn;
	logic [11:0] imm_16sp;
	logic [11:0] imm_lwsp;
	logic [11:0] imm_swsp;
	logic [19:0] imm_lui;
	logic        imm6_zero;

	assign imm_ci   = {{6{c[12]}}, c[12], c[6:2]};
	assign imm_cj   = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
	assign imm_cb   = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
	assign imm_lw   = {5'b0, c[5], c[12:10], c[6], 2'b00};
	assign imm_4spn = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
	assign imm_16sp = {{2{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
	assign imm_lwsp = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
	assign imm_swsp = {4'b0, c[8:7], c[12:9], 2'b00};
	assign imm_lui  = {{14{c[12]}}, c[12], c[6:2]};
	assign imm6_zero = ({c[12], c[6:2]} == 6'd0);

	rv_pkg::word_t exp_instr;
	logic          c_illegal;
	logic          is_32bit;

	always_comb begin
		exp_instr = '0;
		c_illegal = 1'b0;
		case (c[1:0])
		2'b00: begin
			case (c[15:13])
			3'b000: begin // addi4spn, also catches the zero halfword.
				exp_instr = enc_i(imm_4spn, rv_pkg::REG_SP, rv_pkg::F3_ADD, rd_s, rv_pkg::OPC_OP_IMM);
				c_illegal = (c[12:5] == 8'd0);
			end
			3'b010: exp_instr = enc_i(imm_lw, rs1_s, rv_pkg::F3_LW, rd_s, rv_pkg::OPC_LOAD);
			3'b110: exp_instr = enc_s(imm_lw, rs2_s, rs1_s, rv_pkg::F3_SW, rv_pkg::OPC_STORE);
			default: c_illegal = 1'b1; // fp slots and reserved.
			endcase
		end
		2'b01: begin
			case (c[15:13])
			3'b000: exp_instr = enc_i(imm_ci, rd_l, rv_pkg::F3_ADD, rd_l, rv_pkg::OPC_OP_IMM);
			3'b001: exp_instr = enc_j(imm_cj, rv_pkg::REG_RA, rv_pkg::OPC_JAL);
			3'b010: exp_instr = enc_i(imm_ci, rv_pkg::REG_ZERO, rv_pkg::F3_ADD, rd_l,
				rv_pkg::OPC_OP_IMM);
			3'b011: begin
				if (rd_l == rv_pkg::REG_SP) begin // addi16sp.
					exp_instr = enc_i(imm_16sp, rv_pkg::REG_SP, rv_pkg::F3_ADD, rv_pkg::REG_SP,
						rv_pkg::OPC_OP_IMM);
				end else begin
					exp_instr = enc_u(imm_lui, rd_l, rv_pkg::OPC_LUI);
				end
				c_illegal = imm6_zero;
			end
			3'b100: begin
				case (c[11:10])
				2'b00: begin
					exp_instr = enc_i({7'b0, c[6:2]}, rs1_s, rv_pkg::F3_SR, rs1_s, rv_pkg::OPC_OP_IMM);
					c_illegal = c[12]; // shamt[5] is reserved on rv32.
				end
				2'b01: begin
					exp_instr = enc_i({rv_pkg::F7_ALT, c[6:2]}, rs1_s, rv_pkg::F3_SR, rs1_s,
						rv_pkg::OPC_OP_IMM);
					c_illegal = c[12];
				end
				2'b10: exp_instr = enc_i(imm_ci, rs1_s, rv_pkg::F3_AND, rs1_s, rv_pkg::OPC_OP_IMM);
				default: begin
					c_illegal = c[12]; // subw and addw.
					case (c[6:5])
					2'b00: exp_instr = enc_r(rv_pkg::F7_ALT, rs2_s, rs1_s, rv_pkg::F3_ADD, rs1_s,
						rv_pkg::OPC_OP);
					2'b01: exp_instr = enc_r(7'b0, rs2_s, rs1_s, rv_pkg::F3_XOR, rs1_s, rv_pkg::OPC_OP);
					2'b10: exp_instr = enc_r(7'b0, rs2_s, rs1_s, rv_pkg::F3_OR, rs1_s, rv_pkg::OPC_OP);
					default: exp_instr = enc_r(7'b0, rs2_s, rs1_s, rv_pkg::F3_AND, rs1_s,
						rv_pkg::OPC_OP);
					endcase
				end
				endcase
			end
			3'b101: exp_instr = enc_j(imm_cj, rv_pkg::REG_ZERO, rv_pkg::OPC_JAL);
			3'b110: exp_instr = enc_b(imm_cb, rv_pkg::REG_ZERO, rs1_s, rv_pkg::F3_BEQ,
				rv_pkg::OPC_BRANCH);
			default: exp_instr = enc_b(imm_cb, rv_pkg::REG_ZERO, rs1_s, rv_pkg::F3_BNE,
				rv_pkg::OPC_BRANCH);
			endcase
		end
		2'b10: begin
			case (c[15:13])
			3'b000: begin
				exp_instr = enc_i({7'b0, c[6:2]}, rd_l, rv_pkg::F3_SLL, rd_l, rv_pkg::OPC_OP_IMM);
				c_illegal = c[12];
			end
			3'b010: begin
				exp_instr = enc_i(imm_lwsp, rv_pkg::REG_SP, rv_pkg::F3_LW, rd_l, rv_pkg::OPC_LOAD);
				c_illegal = (rd_l == rv_pkg::REG_ZERO);
			end
			3'b100: begin
				if (rs2_l == rv_pkg::REG_ZERO) begin // jr or jalr.
					exp_instr = enc_i(12'h000, rd_l, 3'b000, c[12] ? rv_pkg::REG_RA : rv_pkg::REG_ZERO,
						rv_pkg::OPC_JALR);
					c_illegal = !c[12] && (rd_l == rv_pkg::REG_ZERO);
				end else begin // mv or add.
					exp_instr = enc_r(7'b0, rs2_l, c[12] ? rd_l : rv_pkg::REG_ZERO, rv_pkg::F3_ADD,
						rd_l, rv_pkg::OPC_OP);
				end
			end
			3'b110: exp_instr = enc_s(imm_swsp, rs2_l, rv_pkg::REG_SP, rv_pkg::F3_SW,
				rv_pkg::OPC_STORE);
			default: c_illegal = 1'b1;
			endcase
		end
		default: c_illegal = 1'b0; // not compressed.
		endcase
	end

	assign is_32bit = (head_lo[1:0] == 2'b11);

	always_comb begin
		out.pc       = head_pc;
		out.is_32bit = is_32bit;
		out.illegal  = !is_32bit && c_illegal;
		if (is_32bit) begin
			out.instr = {head_hi, head_lo};
		end else begin
			out.instr = c_illegal ? 32'h0000_0000 : exp_instr;
		end
	end

endmodule

// ==== source/fetch_align_buffer.sv ====
`timescale 1ns/1ps

module fetch_align_buffer (
	input  logic          clk,
	input  logic          arst_n,
	input  logic          resp_accept,
	input  rv_pkg::word_t fetch_rdata,
	input  logic          redirect,
	input  rv_pkg::pc_t   redirect_pc,
	input  logic          stall,
	output logic          buf_room,
	output rv_pkg::half_t head_lo,
	output rv_pkg::half_t head_hi,
	output rv_pkg::pc_t   head_pc,
	output logic          instr_valid
);

	rv_pkg::half_t hw [3]; // stored halfwords, oldest first.
	logic [1:0]    count;
	logic          skip;   // drop the low half of the next word.

	rv_pkg::half_t in_h [2];
	rv_pkg::half_t view [4];
	logic [1:0]    in_n;
	logic [2:0]    avail;
	logic          is32;
	logic [1:0]    need;
	logic          consume;
	logic [1:0]    shift;

	// ##########################################################################
	// head view, stored halves followed by the word arriving now
	// ##########################################################################

	always_comb begin
		in_h[0] = skip ? fetch_rdata[31:16] : fetch_rdata[15:0];
		in_h[1] = fetch_rdata[31:16];
		in_n    = resp_accept ? (skip ? 2'd1 : 2'd2) : 2'd0;
		case (count)
		2'd0: view = '{in_h[0], in_h[1], 16'h0000, 16'h0000};
		2'd1: view = '{hw[0], in_h[0], in_h[1], 16'h0000};
		2'd2: view = '{hw[0], hw[1], in_h[0], in_h[1]};
		default: view = '{hw[0], hw[1], hw[2], in_h[0]};
		endcase
	end

	assign head_lo = view[0];
	assign head_hi = view[1];

	assign is32        = (view[0][1:0] == 2'b11);
	assign need        = is32 ? 2'd2 : 2'd1;
	assign avail       = {1'b0, count} + {1'b0, in_n};
	assign instr_valid = (avail >= {1'b0, need});
	assign consume     = instr_valid && !stall;
	assign shift       = consume ? need : 2'd0;

	// a whole word fits.
	assign buf_room = (count <= 2'd1);

	// ##########################################################################
	// state
	// ##########################################################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count   <= 2'd0;
			skip    <= rv_pkg::RESET_PC[1];
			head_pc <= rv_pkg::RESET_PC;
		end else if (redirect) begin
			count   <= 2'd0; // flush.
			skip    <= redirect_pc[1];
			head_pc <= redirect_pc;
		end else begin
			count <= 2'(avail - {1'b0, shift});
			if (resp_accept) begin
				skip <= 1'b0;
			end
			if (consume) begin
				head_pc <= head_pc + (is32 ? 32'd4 : 32'd2);
			end
		end
	end

	// shift out the consumed halves. slots past count are don't care.
	always_ff @(posedge clk) begin
		hw[0] <= view[shift];
		hw[1] <= view[shift + 2'd1];
		hw[2] <= view[shift + 2'd2];
	end

endmodule

// ==== source/fetch_addr_gen.sv ====
`timescale 1ns/1ps

module fetch_addr_gen (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        redirect,
	input  rv_pkg::pc_t redirect_pc,
	input  logic        buf_room,
	input  logic        fetch_rvalid,
	output logic        fetch_req,
	output rv_pkg::pc_t fetch_addr,
	output logic        resp_accept
);

	rv_pkg::fetch_state_e state;
	rv_pkg::pc_t          next_addr;
	rv_pkg::pc_t          redir_word;
	rv_pkg::pc_t          req_addr;

	assign redir_word = {redirect_pc[31:2], 2'b00};
	assign req_addr   = redirect ? redir_word : next_addr;

	// a response racing a redirect is stale as well.
	assign resp_accept = fetch_rvalid && (state == rv_pkg::FETCH_WAIT) && !redirect;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= rv_pkg::FETCH_IDLE;
			next_addr  <= rv_pkg::RESET_PC;
			fetch_addr <= rv_pkg::RESET_PC;
			fetch_req  <= 1'b0;
		end else begin
			fetch_req <= 1'b0; // single cycle pulse.
			if (redirect) begin
				next_addr <= redir_word;
			end
			case (state)
			rv_pkg::FETCH_IDLE: begin
				if (redirect || buf_room) begin
					fetch_req  <= 1'b1;
					fetch_addr <= req_addr;
					next_addr  <= req_addr + 32'd4;
					state      <= rv_pkg::FETCH_WAIT;
				end
			end
			rv_pkg::FETCH_WAIT: begin
				if (fetch_rvalid) begin
					state <= rv_pkg::FETCH_IDLE;
				end else if (redirect) begin
					state <= rv_pkg::FETCH_DROP;
				end
			end
			default: begin // drop, wait out the old response.
				if (fetch_rvalid) begin
					state <= rv_pkg::FETCH_IDLE;
				end
			end
			endcase
		end
	end

endmodule

// ==== source/instr_fetch_top.sv ====
`timescale 1ns/1ps

module instr_fetch_top (
	input  logic               clk,
	input  logic               arst_n,
	output logic               fetch_req,
	output rv_pkg::pc_t        fetch_addr,
	input  logic               fetch_rvalid,
	input  rv_pkg::word_t      fetch_rdata,
	input  logic               redirect,
	input  rv_pkg::pc_t        redirect_pc,
	input  logic               stall,
	output logic               instr_valid,
	output rv_pkg::fetch_out_t out
);

	logic          buf_room;
	logic          resp_accept;
	rv_pkg::half_t head_lo;
	rv_pkg::half_t head_hi;
	rv_pkg::pc_t   head_pc;

	fetch_addr_gen u_addr_gen (
		.clk          (clk),
		.arst_n       (arst_n),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.buf_room     (buf_room),
		.fetch_rvalid (fetch_rvalid),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.resp_accept  (resp_accept)
	);

	fetch_align_buffer u_align (
		.clk         (clk),
		.arst_n      (arst_n),
		.resp_accept (resp_accept),
		.fetch_rdata (fetch_rdata),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.stall       (stall),
		.buf_room    (buf_room),
		.head_lo     (head_lo),
		.head_hi     (head_hi),
		.head_pc     (head_pc),
		.instr_valid (instr_valid)
	);

	instr_decompress u_decomp (
		.head_lo (head_lo),
		.head_hi (head_hi),
		.head_pc (head_pc),
		.out     (out)
	);

endmodule

// ==== tests/tb_rvc_model.svh ====
`ifndef TB_RVC_MODEL_SVH
`define TB_RVC_MODEL_SVH

// ############################################################################
// random source and program image
// ############################################################################

logic [31:0]   lcg_state;
rv_pkg::word_t mem [MEM_WORDS];

function logic [31:0] next_rand();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic rv_pkg::half_t half_at(input rv_pkg::pc_t a);
	rv_pkg::word_t w;
	w = mem[a[9:2]]; // image wraps every 1 KiB.
	return a[1] ? w[31:16] : w[15:0];
endfunction

// ############################################################################
// rvc expansion, bit 32 of the result is the illegal flag
// ############################################################################

function automatic logic [32:0] expand_rvc(input rv_pkg::half_t c);
	rv_pkg::word_t     w;
	logic              bad;
	rv_pkg::reg_addr_t rd;
	rv_pkg::reg_addr_t rs2;
	rv_pkg::reg_addr_t rdp;
	rv_pkg::reg_addr_t rs1p;
	w    = '0;
	bad  = 1'b0;
	rd   = c[11:7];
	rs2  = c[6:2];
	rdp  = {2'b01, c[4:2]};
	rs1p = {2'b01, c[9:7]};
	case ({c[1:0], c[15:13]})
	5'b00_000: begin
		w = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, rv_pkg::REG_SP, rv_pkg::F3_ADD, rdp,
			rv_pkg::OPC_OP_IMM};
		bad = (c[12:5] == 8'd0);
	end
	5'b00_010: w = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1p, rv_pkg::F3_LW, rdp, rv_pkg::OPC_LOAD};
	5'b00_110: w = {5'b0, c[5], c[12], rdp, rs1p, rv_pkg::F3_SW, c[11:10], c[6], 2'b00,
		rv_pkg::OPC_STORE};
	5'b01_000: w = {{7{c[12]}}, c[6:2], rd, rv_pkg::F3_ADD, rd, rv_pkg::OPC_OP_IMM};
	5'b01_001, 5'b01_101: w = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
		{9{c[12]}}, (c[15] ? rv_pkg::REG_ZERO : rv_pkg::REG_RA), rv_pkg::OPC_JAL};
	5'b01_010: w = {{7{c[12]}}, c[6:2], rv_pkg::REG_ZERO, rv_pkg::F3_ADD, rd, rv_pkg::OPC_OP_IMM};
	5'b01_011: begin
		if (rd == rv_pkg::REG_SP) begin
			w = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, rv_pkg::REG_SP, rv_pkg::F3_ADD,
				rv_pkg::REG_SP, rv_pkg::OPC_OP_IMM};
		end else begin
			w = {{15{c[12]}}, c[6:2], rd, rv_pkg::OPC_LUI};
		end
		bad = ({c[12], c[6:2]} == 6'd0);
	end
	5'b01_100: begin
		case (c[11:10])
		2'b00: begin
			w = {7'b0, c[6:2], rs1p, rv_pkg::F3_SR, rs1p, rv_pkg::OPC_OP_IMM};
			bad = c[12];
		end
		2'b01: begin
			w = {rv_pkg::F7_ALT, c[6:2], rs1p, rv_pkg::F3_SR, rs1p, rv_pkg::OPC_OP_IMM};
			bad = c[12];
		end
		2'b10: w = {{7{c[12]}}, c[6:2], rs1p, rv_pkg::F3_AND, rs1p, rv_pkg::OPC_OP_IMM};
		default: begin
			bad = c[12];
			case (c[6:5])
			2'b00: w = {rv_pkg::F7_ALT, rdp, rs1p, rv_pkg::F3_ADD, rs1p, rv_pkg::OPC_OP};
			2'b01: w = {7'b0, rdp, rs1p, rv_pkg::F3_XOR, rs1p, rv_pkg::OPC_OP};
			2'b10: w = {7'b0, rdp, rs1p, rv_pkg::F3_OR, rs1p, rv_pkg::OPC_OP};
			default: w = {7'b0, rdp, rs1p, rv_pkg::F3_AND, rs1p, rv_pkg::OPC_OP};
			endcase
		end
		endcase
	end
	5'b01_110, 5'b01_111: w = {{4{c[12]}}, c[6:5], c[2], rv_pkg::REG_ZERO, rs1p,
		(c[13] ? rv_pkg::F3_BNE : rv_pkg::F3_BEQ), c[11:10], c[4:3], c[12], rv_pkg::OPC_BRANCH};
	5'b10_000: begin
		w = {7'b0, c[6:2], rd, rv_pkg::F3_SLL, rd, rv_pkg::OPC_OP_IMM};
		bad = c[12];
	end
	5'b10_010: begin
		w = {4'b0, c[3:2], c[12], c[6:4], 2'b00, rv_pkg::REG_SP, rv_pkg::F3_LW, rd, rv_pkg::OPC_LOAD};
		bad = (rd == rv_pkg::REG_ZERO);
	end
	5'b10_100: begin
		if (rs2 == rv_pkg::REG_ZERO) begin
			w = {12'b0, rd, 3'b000, (c[12] ? rv_pkg::REG_RA : rv_pkg::REG_ZERO), rv_pkg::OPC_JALR};
			bad = !c[12] && (rd == rv_pkg::REG_ZERO);
		end else begin
			w = {7'b0, rs2, (c[12] ? rd : rv_pkg::REG_ZERO), rv_pkg::F3_ADD, rd, rv_pkg::OPC_OP};
		end
	end
	5'b10_110: w = {4'b0, c[8:7], c[12], rs2, rv_pkg::REG_SP, rv_pkg::F3_SW, c[11:9], 2'b00,
		rv_pkg::OPC_STORE};
	default: bad = 1'b1;
	endcase
	if (bad) begin
		w = '0;
	end
	return {bad, w};
endfunction

// expected decoder view of the instruction at pc.
function automatic rv_pkg::fetch_out_t model_out(input rv_pkg::pc_t pc);
	rv_pkg::fetch_out_t o;
	rv_pkg::half_t      lo;
	logic [32:0]        r;
	lo = half_at(pc);
	r  = expand_rvc(lo);
	o.pc = pc;
	if (lo[1:0] == 2'b11) begin
		o.instr    = {half_at(pc + 32'd2), lo};
		o.is_32bit = 1'b1;
		o.illegal  = 1'b0;
	end else begin
		o.instr    = r[31:0];
		o.is_32bit = 1'b0;
		o.illegal  = r[32];
	end
	return o;
endfunction

// mostly legal compressed parcels, some 32-bit words, a few illegal halves.
task automatic gen_program();
	rv_pkg::half_t halves [2 * MEM_WORDS];
	rv_pkg::half_t h;
	logic [31:0]   x;
	logic [31:0]   y;
	logic [32:0]   r;
	int            i;
	i = 0;
	while (i < 2 * MEM_WORDS) begin
		x = next_rand();
		if (x[3:0] < 4'd5) begin
			y = next_rand();
			halves[i] = {x[31:18], 2'b11};
			halves[(i + 1) % (2 * MEM_WORDS)] = y[15:0];
			i = i + 2;
		end else if (x[9:4] == 6'd0) begin
			halves[i] = 16'h0000;
			i = i + 1;
		end else begin
			do begin
				y = next_rand();
				h = {y[15:2], (y[17:16] == 2'b11) ? 2'b10 : y[17:16]};
				r = expand_rvc(h);
			end while (r[32] && (y[21:18] != 4'd0));
			halves[i] = h;
			i = i + 1;
		end
	end
	for (int k = 0; k < MEM_WORDS; k++) begin
		mem[k] = {halves[2 * k + 1], halves[2 * k]};
	end
endtask

`endif

// ==== tests/tb_instr_fetch.sv ====
`timescale 1ns/1ps

module tb_instr_fetch;

	localparam int          MEM_WORDS  = 256;
	localparam int          MAX_IDLE   = 200;  // cycles without a consumed instruction.
	localparam int          RUN_CYCLES = 6000;
	localparam int          MIN_INSTR  = 500;
	localparam logic [31:0] SEED       = 32'h772c0f36;

	logic               clk = 1'b0;
	logic               arst_n;
	logic               fetch_req;
	rv_pkg::pc_t        fetch_addr;
	logic               fetch_rvalid;
	rv_pkg::word_t      fetch_rdata;
	logic               redirect;
	rv_pkg::pc_t        redirect_pc;
	logic               stall;
	logic               instr_valid;
	rv_pkg::fetch_out_t out;

	`include "tb_rvc_model.svh"

	instr_fetch_top uut (
		.clk          (clk),
		.arst_n       (arst_n),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.fetch_rvalid (fetch_rvalid),
		.fetch_rdata  (fetch_rdata),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.stall        (stall),
		.instr_valid  (instr_valid),
		.out          (out)
	);

	always #50 clk = ~clk;

	task automatic check_out(input string name, input rv_pkg::fetch_out_t got,
		input rv_pkg::fetch_out_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// ##########################################################################
	// stimulus, memory responder and checks in one process
	// ##########################################################################

	logic               pending;   // memory owes a response.
	int                 wait_cnt;
	rv_pkg::pc_t        resp_addr;
	rv_pkg::pc_t        model_pc;
	logic               hold;      // last cycle stalled a valid head.
	int                 idle;
	int                 consumed;
	logic [31:0]        r;

	initial begin
		arst_n       = 1'b0;
		fetch_rvalid = 1'b0;
		fetch_rdata  = '0;
		redirect     = 1'b0;
		redirect_pc  = '0;
		stall        = 1'b0;
		pending      = 1'b0;
		wait_cnt     = 0;
		resp_addr    = '0;
		model_pc     = rv_pkg::RESET_PC;
		hold         = 1'b0;
		idle         = 0;
		consumed     = 0;
		lcg_state    = SEED;
		gen_program();

		repeat (10) begin
			@(negedge clk);
			check_flag("fetch_req", fetch_req, 1'b0);
			check_flag("instr_valid", instr_valid, 1'b0);
		end
		arst_n = 1'b1;

		for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			@(negedge clk);
			if (cyc == 0) begin
				check_flag("fetch_req", fetch_req, 1'b1); // first edge after release.
			end
			fetch_rvalid = 1'b0;
			if (pending) begin
				wait_cnt = wait_cnt - 1;
				if (wait_cnt == 0) begin
					fetch_rvalid = 1'b1;
					fetch_rdata  = mem[resp_addr[9:2]];
					pending      = 1'b0;
				end
			end
			if (fetch_req) begin
				check_flag("fetch_req_single_outstanding", pending, 1'b0);
				check_flag("fetch_addr_aligned", fetch_addr[1:0] == 2'b00, 1'b1);
				r         = next_rand();
				pending   = 1'b1;
				resp_addr = fetch_addr;
				wait_cnt  = int'(r[2:0]) + 1;
			end
			r           = next_rand();
			stall       = (r[1:0] == 2'b00);
			// the first instruction always comes from the reset vector.
			redirect    = (consumed > 0) &&
				((r[7:3] == 5'd0) || (pending && r[11:8] == 4'd0));
			redirect_pc = {22'b0, r[21:13], 1'b0};

			#10;
			if (hold) begin
				check_flag("instr_valid", instr_valid, 1'b1);
			end
			if (instr_valid) begin
				check_out("out", out, model_out(model_pc));
			end

			hold = stall && instr_valid && !redirect;
			if (redirect) begin
				model_pc = redirect_pc;
				idle     = idle + 1;
			end else if (instr_valid && !stall) begin
				model_pc = model_pc + (out.is_32bit ? 32'd4 : 32'd2);
				consumed = consumed + 1;
				idle     = 0;
			end else begin
				idle = idle + 1;
			end
			if (idle > MAX_IDLE) begin
				$display("no instruction was consumed for %0d cycles", MAX_IDLE);
				$display("TEST FAILED");
				$fatal(1);
			end
		end

		if (consumed < MIN_INSTR) begin
			$display("only %0d instructions were consumed", consumed);
			$display("TEST FAILED");
			$fatal(1);
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// ==== flist.f ====
+incdir+tests
source/rv_pkg.sv
source/instr_decompress.sv
source/fetch_align_buffer.sv
source/fetch_addr_gen.sv
source/instr_fetch_top.sv
tests/tb_instr_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -j 0 -f flist.f --top-module tb_instr_fetch -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1
